// ==== haar_stage.f ====
haar_types_pkg.sv
stage_ctrl_pkg.sv
weak_classifier.sv
stage_accumulator.sv
haar_stage.sv
tb_clock_gen.sv
haar_stage_assertions.sv
haar_stage_tb.sv

// ==== haar_stage.sv ====
`timescale 1ns/10ps

module haar_stage
	import haar_types_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  logic          req,
	input  stage_req_t    stage_req,
	output logic          ack,
	output stage_result_t result
);

	logic                     start;
	logic signed [vote_w-1:0] vote_a;
	logic signed [vote_w-1:0] vote_b;
	logic                     valid_a;
	logic                     valid_b;
	logic                     vote_valid;

	// Both classifiers run in lockstep
	assign vote_valid = valid_a & valid_b;

	stage_accumulator u_acc (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req),
		.stage_thr  (stage_req.stage_thr),
		.vote_a     (vote_a),
		.vote_b     (vote_b),
		.vote_valid (vote_valid),
		.start      (start),
		.ack        (ack),
		.result     (result)
	);

	// Features are read straight from the request, stable while req is high
	weak_classifier u_clf_a (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.feature    (stage_req.feature_a),
		.vote       (vote_a),
		.vote_valid (valid_a)
	);

	weak_classifier u_clf_b (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.feature    (stage_req.feature_b),
		.vote       (vote_b),
		.vote_valid (valid_b)
	);

endmodule

// ==== haar_stage_assertions.sv ====
`timescale 1ns/10ps

module haar_stage_assertions
	import haar_types_pkg::*;
(
	input logic          clk,
	input logic          rst_n,
	input logic          req,
	input logic          ack,
	input logic          start,
	input stage_result_t result
);

	// ack answers a request, it never rises on its own
	ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ack) |-> $past(req))
		else $error("ack rose without a pending req");

	// Only the requester releases the handshake
	ack_held_by_req: assert property (@(posedge clk) disable iff (!rst_n)
		(ack && req) |=> ack)
		else $error("ack fell while req was still high");

	// Result frozen for the whole ack phase
	result_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(ack && $past(ack)) |-> $stable(result))
		else $error("result changed while ack was high");

	// No new evaluation before the handshake completes
	no_start_in_ack: assert property (@(posedge clk) disable iff (!rst_n)
		ack |-> !start)
		else $error("start issued while ack was high");

endmodule

// ==== haar_stage_tb.sv ====
`timescale 1ns/10ps

module haar_stage_tb
	import haar_types_pkg::*;
;

	localparam int num_requests   = 400;
	localparam int ack_latency    = 3;                      // Edges from req sampled to ack
	localparam int timeout_cycles = num_requests * 12 + 100;

	logic          clk;
	logic          rst_n;
	logic          req;
	stage_req_t    stage_req;
	logic          ack;
	stage_result_t result;

	integer seed = 32'h3952;
	int     cycle_count = 0;

	tb_clock_gen u_clk (.clk(clk));

	haar_stage DUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.stage_req (stage_req),
		.ack       (ack),
		.result    (result)
	);

	bind haar_stage haar_stage_assertions u_checks (
		.clk    (clk),
		.rst_n  (rst_n),
		.req    (req),
		.ack    (ack),
		.start  (start),
		.result (result)
	);

	task automatic report_value(input string name, input int expected, input int actual);
		$display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1);
	endtask

	// Reference model of one rectangle, one feature and its vote
	function automatic int rect_value(input haar_rect_t r);
		return (int'(r.a) - int'(r.b) + int'(r.c) - int'(r.d)) * int'(r.weight);
	endfunction

	function automatic int feature_value(input haar_feature_t f);
		return rect_value(f.rect1) + rect_value(f.rect3) - rect_value(f.rect2);
	endfunction

	function automatic int selected_vote(input haar_feature_t f);
		if (feature_value(f) > int'(f.feature_thr))
			return int'(f.right_word);
		return int'(f.left_word);
	endfunction

	task automatic random_rect(input bit extreme, output haar_rect_t r);
		if (extreme) begin
			r.a      = ($random(seed) & 1) ? 8'hff : 8'h00;  // Corners at 0 or 255
			r.b      = ($random(seed) & 1) ? 8'hff : 8'h00;
			r.c      = ($random(seed) & 1) ? 8'hff : 8'h00;
			r.d      = ($random(seed) & 1) ? 8'hff : 8'h00;
			r.weight = ($random(seed) & 1) ? 8'h7f : 8'h80;  // 127 or -128
		end else begin
			r.a      = 8'($random(seed));
			r.b      = 8'($random(seed));
			r.c      = 8'($random(seed));
			r.d      = 8'($random(seed));
			r.weight = 8'($random(seed));
		end
	endtask

	task automatic make_feature(input bit extreme, input bit bias, output haar_feature_t f);
		int v;
		random_rect(extreme, f.rect1);
		random_rect(extreme, f.rect2);
		random_rect(extreme, f.rect3);
		f.feature_thr = 16'($random(seed));
		f.left_word   = 12'($random(seed));
		f.right_word  = 12'($random(seed));
		if (bias) begin
			v = feature_value(f) + ($random(seed) % 2);      // Just below, at or above
			if (v > 32767)
				v = 32767;
			if (v < -32768)
				v = -32768;
			f.feature_thr = 16'(v);
		end
	endtask

	// One full four-phase handshake with checks on timing and result
	task automatic run_request(input stage_req_t sr, input int hold);
		int  exp_sum;
		bit  exp_pass;
		int  edges;
		exp_sum  = selected_vote(sr.feature_a) + selected_vote(sr.feature_b);
		exp_pass = (exp_sum >= int'(sr.stage_thr));
		stage_req = sr;
		req       = 1'b1;
		edges     = -1;                                      // First edge samples req
		while (ack !== 1'b1) begin
			@(negedge clk);
			edges++;
			if (edges > 8)
				abort_run("ack did not rise within 8 cycles of req");
		end
		assert (edges == ack_latency)
			else report_value("ack latency", ack_latency, edges);
		assert (int'(result.stage_sum) == exp_sum)
			else report_value("result.stage_sum", exp_sum, int'(result.stage_sum));
		assert (result.pass == exp_pass)
			else report_value("result.pass", int'(exp_pass), int'(result.pass));
		repeat (hold) begin
			@(negedge clk);
			assert (ack == 1'b1)
				else report_value("ack", 1, int'(ack));
			assert (int'(result.stage_sum) == exp_sum)
				else report_value("result.stage_sum", exp_sum, int'(result.stage_sum));
			assert (result.pass == exp_pass)
				else report_value("result.pass", int'(exp_pass), int'(result.pass));
		end
		req = 1'b0;
		@(negedge clk);
		assert (ack == 1'b0)
			else report_value("ack", 0, int'(ack));
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
			abort_run("Timeout: the run exceeded its cycle limit");
	end

	initial begin
		stage_req_t sr;
		bit         bias;
		bit         extreme;
		int         hold;
		rst_n     = 1'b0;
		req       = 1'b0;
		stage_req = '0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		assert (ack == 1'b0)
			else report_value("ack", 0, int'(ack));
		assert (result == '0)
			else report_value("result", 0, int'(result));
		for (int i = 0; i < num_requests; i++) begin
			bias    = (i % 4 == 1);                           // Thresholds near the value
			extreme = (i % 8 == 2) || (i % 8 == 5);
			make_feature(extreme, bias, sr.feature_a);
			make_feature(extreme, bias, sr.feature_b);
			if (bias)
				sr.stage_thr = 14'(selected_vote(sr.feature_a) + selected_vote(sr.feature_b)
					+ ($random(seed) % 2));
			else
				sr.stage_thr = 14'($random(seed) % 3000);
			hold = {$random(seed)} % 6;                       // Extra cycles with req held
			run_request(sr, hold);
		end
		$display("** PASS **");
		$finish;
	end

endmodule

// ==== haar_types_pkg.sv ====
package haar_types_pkg;

	// Datapath widths
	localparam int corner_w = 8;    // Integral image corner, unsigned
	localparam int weight_w = 8;    // Rectangle weight, signed
	localparam int vote_w   = 12;   // Left or right vote word, signed
	localparam int fthr_w   = 16;   // Feature threshold, signed
	localparam int value_w  = 20;   // Weighted feature value, signed
	localparam int sum_w    = 14;   // Stage sum and stage threshold, signed

	// Signed vote word carried by a feature and returned by a classifier
	typedef logic signed [vote_w-1:0] vote_t;

	// One rectangle: four integral corners and a weight, 40 bits
	typedef struct packed {
		logic [corner_w-1:0]        a;
		logic [corner_w-1:0]        b;
		logic [corner_w-1:0]        c;
		logic [corner_w-1:0]        d;
		logic signed [weight_w-1:0] weight;
	} haar_rect_t;

	// One Haar feature, 160 bits
	// Value is rect1 + rect3 - rect2, compared against feature_thr
	typedef struct packed {
		haar_rect_t               rect1;
		haar_rect_t               rect2;
		haar_rect_t               rect3;
		logic signed [fthr_w-1:0] feature_thr;
		vote_t                    left_word;    // Selected when value <= threshold
		vote_t                    right_word;   // Selected when value > threshold
	} haar_feature_t;

	// Stage request: two features and the stage threshold, 334 bits
	typedef struct packed {
		haar_feature_t           feature_a;
		haar_feature_t           feature_b;
		logic signed [sum_w-1:0] stage_thr;
	} stage_req_t;

	// Stage result, 15 bits
	typedef struct packed {
		logic signed [sum_w-1:0] stage_sum;  // Sum of both votes
		logic                    pass;       // stage_sum >= stage_thr
	} stage_result_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator, exit status reports pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert \
	--top-module haar_stage_tb \
	-f haar_stage.f \
	-o haar_stage_sim \
	&& ./obj_dir/haar_stage_sim \
	|| exit 1

// ==== stage_accumulator.sv ====
`timescale 1ns/10ps

module stage_accumulator
	import haar_types_pkg::*, stage_ctrl_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     req,
	input  logic signed [sum_w-1:0]  stage_thr,
	input  logic signed [vote_w-1:0] vote_a,
	input  logic signed [vote_w-1:0] vote_b,
	input  logic                     vote_valid,
	output logic                     start,
	output logic                     ack,
	output stage_result_t            result
);

	acc_state_t               state;
	logic [clf_latency-1:0]   issue_pipe;   // Tracks the issued start through the classifiers
	logic                     votes_due;
	logic signed [sum_w-1:0]  vote_sum;
	logic                     vote_pass;

	// Votes are accepted only when the issued start has reached the end of the pipeline
	assign votes_due = issue_pipe[clf_latency-1];

	// Sign-extended sum of both votes and the stage decision
	always_comb begin
		vote_sum  = sum_w'(vote_a) + sum_w'(vote_b);
		vote_pass = (vote_sum >= stage_thr);
	end

	// Issue tracking, one bit per classifier stage
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			issue_pipe <= '0;
		end else begin
			issue_pipe <= {issue_pipe[clf_latency-2:0], start};
		end
	end

	// Handshake FSM
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state  <= IDLE;
			start  <= 1'b0;
			ack    <= 1'b0;
			result <= '0;
		end else begin
			start <= 1'b0;                      // One-cycle pulse
			case (state)
				IDLE: begin
					if (req) begin
						start <= 1'b1;          // Issue both classifiers
						state <= EVAL;
					end
				end
				EVAL: begin
					if (vote_valid && votes_due) begin
						result.stage_sum <= vote_sum;
						result.pass      <= vote_pass;
						ack              <= 1'b1;
						state            <= DONE;
					end
				end
				DONE: begin
					// Hold ack and result until the requester lets go
					if (!req) begin
						ack   <= 1'b0;
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

// ==== stage_ctrl_pkg.sv ====
package stage_ctrl_pkg;

	// Stage accumulator states
	// IDLE waits for req, EVAL waits for both votes,
	// DONE holds ack and result until req falls
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		EVAL = 2'd1,
		DONE = 2'd2
	} acc_state_t;

	// Cycles from a classifier start to its vote_valid
	// Stage 1 holds the weighted rectangle terms, stage 2 the selected vote
	localparam int clf_latency = 2;

endpackage

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk
);

	localparam time half_period = 20ns;    // 40 ns period

	initial begin
		clk = 1'b0;
	end

	always #(half_period) clk = ~clk;

endmodule

// ==== weak_classifier.sv ====
`timescale 1ns/10ps

module weak_classifier
	import haar_types_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      start,
	input  haar_feature_t             feature,
	output logic signed [vote_w-1:0]  vote,
	output logic                      vote_valid
);

	localparam int diff_w = corner_w + 2;           // (A-B)+(C-D) spans -510..510
	localparam int term_w = diff_w + weight_w;      // Weighted rectangle term

	// Weighted rectangle: ((A-B)+(C-D)) * weight
	function automatic logic signed [term_w-1:0] rect_term(input haar_rect_t r);
		logic signed [diff_w-1:0] diff;
		logic signed [term_w-1:0] prod;
		diff = $signed({2'b00, r.a}) - $signed({2'b00, r.b})
			+ $signed({2'b00, r.c}) - $signed({2'b00, r.d});
		prod = diff * r.weight;                     // Signed 10x8 fits in 18 bits
		return prod;
	endfunction

	// Stage 1 registers
	logic                      s1_valid;
	logic signed [term_w-1:0]  s1_term1;
	logic signed [term_w-1:0]  s1_term2;
	logic signed [term_w-1:0]  s1_term3;
	logic signed [fthr_w-1:0]  s1_thr;
	vote_t                     s1_left;
	vote_t                     s1_right;

	// Stage 2 combinational
	logic signed [value_w-1:0] value;
	logic signed [value_w-1:0] thr_ext;
	logic                      above;

	// Stage 1: three weighted rectangle terms, feature words carried along
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= start;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			s1_term1 <= rect_term(feature.rect1);
			s1_term2 <= rect_term(feature.rect2);
			s1_term3 <= rect_term(feature.rect3);
			s1_thr   <= feature.feature_thr;
			s1_left  <= feature.left_word;
			s1_right <= feature.right_word;
		end
	end

	// Feature value and signed threshold compare
	always_comb begin
		value   = value_w'(s1_term1) + value_w'(s1_term3) - value_w'(s1_term2);
		thr_ext = value_w'(s1_thr);                 // Sign extension
		above   = (value > thr_ext);                // Strict greater-than
	end

	// Stage 2: vote selection
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vote_valid <= 1'b0;
		end else begin
			vote_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			vote <= above ? s1_right : s1_left;
		end
	end

endmodule
